// ==== Bender.yml ====
package:
  name: pixel_pipeline

sources:
  - source/pixelPipelinePkg.sv
  - source/pipelineCtrlIf.sv
  - source/pipelineControl.sv
  - source/sidebandDelay.sv
  - source/texelAddressGen.sv
  - source/texEnvCombiner.sv
  - source/fogUnit.sv
  - source/pixelPipelineTop.sv
  - target: test
    files:
      - tests/texelMemModel.sv
      - tests/pixelPipelineTb.sv

// ==== source/fogUnit.sv ====
// Fog unit
// Looks up a fog factor by W and blends the color toward the fog color

`timescale 1ns/1ps

module fogUnit (
    input  logic aclk,

    input  logic [31:0] attrbDepthW,
    input  logic [pixelPipelinePkg::pixelWidth-1:0] texColor,
    input  logic [pixelPipelinePkg::pixelWidth-1:0] confFogColor,

    input  logic fogLutWrEn,
    input  logic [pixelPipelinePkg::fogLutIndexWidth-1:0] fogLutWrAddr,
    input  logic [31:0] fogLutData,

    output logic [pixelPipelinePkg::pixelWidth-1:0] fragColor,

    pipelineCtrlIf.stage ctrl
);
    localparam int chanWidth = pixelPipelinePkg::subPixelWidth;
    localparam int chanCount = pixelPipelinePkg::pixelWidth / chanWidth;
    localparam int lutMaxIndex = pixelPipelinePkg::fogLutDepth - 1;

    logic [chanWidth-1:0] fogLut [pixelPipelinePkg::fogLutDepth];
    logic [31:0] depthWPipe [2];
    logic [15:0] depthWInt;
    logic [pixelPipelinePkg::fogLutIndexWidth-1:0] lutIndex;
    logic [chanWidth-1:0] fogFactor;
    logic [pixelPipelinePkg::pixelWidth-1:0] foggedColor;

    function automatic logic [chanWidth-1:0] blendChannel(
        input logic [chanWidth-1:0] color,
        input logic [chanWidth-1:0] fog,
        input logic [chanWidth-1:0] factor
    );
        logic [2*chanWidth-1:0] mix;
        mix = color * factor + fog * (8'd255 - factor) + 16'd255;
        return mix[2*chanWidth-1:chanWidth];
    endfunction

    ////////////////////////////////////////
    // Factor table
    ////////////////////////////////////////
    always_ff @(posedge aclk)
    begin
        if (fogLutWrEn)
            fogLut[fogLutWrAddr] <= fogLutData[chanWidth-1:0];
    end

    // Integer part of Q16.16, saturated to the last entry
    assign depthWInt = depthWPipe[1][31:16];
    assign lutIndex = (depthWInt > lutMaxIndex)
                      ? lutMaxIndex[pixelPipelinePkg::fogLutIndexWidth-1:0]
                      : depthWInt[pixelPipelinePkg::fogLutIndexWidth-1:0];

    ////////////////////////////////////////
    // Blend
    ////////////////////////////////////////
    always_comb
    begin
        // Alpha in the bottom byte is kept
        foggedColor = texColor;
        for (int i = 1; i < chanCount; i++)
        begin
            foggedColor[i*chanWidth +: chanWidth] = blendChannel(
                texColor[i*chanWidth +: chanWidth],
                confFogColor[i*chanWidth +: chanWidth], fogFactor);
        end
    end

    always_ff @(posedge aclk)
    begin
        if (ctrl.stageEnable)
        begin
            depthWPipe[0] <= attrbDepthW;
            depthWPipe[1] <= depthWPipe[0];
            fogFactor <= fogLut[lutIndex];
            fragColor <= ctrl.fogEnable ? foggedColor : texColor;
        end
    end

endmodule

// ==== source/pipelineControl.sv ====
// Pixel pipeline control
// Stage enable, valid/last tracking, config decode and fog table write pointer

`timescale 1ns/1ps

module pipelineControl (
    input  logic aclk,
    input  logic rstN,

    input  logic fragReady,
    input  logic attrbValid,
    input  logic attrbLast,
    output logic attrbReady,
    output logic fragValid,
    output logic fragLast,

    input  logic [31:0] confFeatureEnable,
    input  logic [31:0] confTexEnvConfig,

    input  logic fogLutValid,
    input  logic fogLutLast,
    output logic fogLutReady,
    output logic fogLutWrEn,
    output logic [pixelPipelinePkg::fogLutIndexWidth-1:0] fogLutWrAddr,

    pipelineCtrlIf.ctrl ctrl
);
    localparam int depth = pixelPipelinePkg::pipeDepth;

    logic [depth-1:0] validPipe;
    logic [depth-1:0] lastPipe;
    logic [pixelPipelinePkg::texEnvFuncWidth-1:0] funcCode;

    // Downstream ready stalls the whole pipeline
    assign ctrl.stageEnable = fragReady;
    assign attrbReady = fragReady;

    ////////////////////////////////////////
    // Configuration decode
    ////////////////////////////////////////
    assign ctrl.tmuEnable = confFeatureEnable[pixelPipelinePkg::featureTmuPos];
    assign ctrl.fogEnable = confFeatureEnable[pixelPipelinePkg::featureFogPos];

    assign funcCode = confTexEnvConfig[pixelPipelinePkg::texEnvFuncWidth-1:0];
    // Unused code 3 falls back to replace
    assign ctrl.texEnvFunc = (funcCode == pixelPipelinePkg::texEnvModulate
                              || funcCode == pixelPipelinePkg::texEnvAdd)
                             ? funcCode : pixelPipelinePkg::texEnvReplace;

    // Valid and last follow the fragment through all stages
    always_ff @(posedge aclk)
    begin
        if (!rstN)
        begin
            validPipe <= '0;
            lastPipe <= '0;
        end
        else if (fragReady)
        begin
            validPipe <= {validPipe[depth-2:0], attrbValid};
            lastPipe <= {lastPipe[depth-2:0], attrbValid & attrbLast};
        end
    end

    assign fragValid = validPipe[depth-1];
    assign fragLast = lastPipe[depth-1];

    ////////////////////////////////////////
    // Fog table write pointer
    ////////////////////////////////////////
    assign fogLutReady = 1'b1;
    assign fogLutWrEn = fogLutValid;

    always_ff @(posedge aclk)
    begin
        if (!rstN)
            fogLutWrAddr <= '0;
        else if (fogLutValid)
            fogLutWrAddr <= fogLutLast ? '0 : fogLutWrAddr + 1'b1;
    end

    // Stream ends with last on the top entry at the latest
    assert property (@(posedge aclk) disable iff (!rstN)
        fogLutValid && !fogLutLast |-> fogLutWrAddr < pixelPipelinePkg::fogLutDepth - 1);

    assert property (@(posedge aclk) disable iff (!rstN)
        !$isunknown(fragValid));

endmodule

// ==== source/pipelineCtrlIf.sv ====
// Pipeline control bus
// Stage enable and decoded configuration, from control to the datapath

`timescale 1ns/1ps

interface pipelineCtrlIf;
    // Every pipeline register advances only while high
    logic stageEnable;
    logic tmuEnable;
    logic fogEnable;
    logic [pixelPipelinePkg::texEnvFuncWidth-1:0] texEnvFunc;

    modport ctrl (
        output stageEnable,
        output tmuEnable,
        output fogEnable,
        output texEnvFunc
    );

    modport stage (
        input stageEnable,
        input tmuEnable,
        input fogEnable,
        input texEnvFunc
    );
endinterface

// ==== source/pixelPipelinePkg.sv ====
// Pixel pipeline definitions
// Widths, pipeline depth, fog table size, feature bits and texture env codes

package pixelPipelinePkg;

    ////////////////////////////////////////
    // Color format
    ////////////////////////////////////////
    // One color channel
    localparam int subPixelWidth = 8;
    // RGBA8888 with red in the top byte and alpha in the bottom byte
    localparam int pixelWidth = 32;

    // Enabled edges from an accepted fragment to the outputs
    localparam int pipeDepth = 4;

    ////////////////////////////////////////
    // Fog factor table
    ////////////////////////////////////////
    localparam int fogLutDepth = 32;
    localparam int fogLutIndexWidth = 5;

    ////////////////////////////////////////
    // Configuration words
    ////////////////////////////////////////
    // Feature enable bits
    localparam int featureTmuPos = 0;
    localparam int featureFogPos = 1;

    // Texture env function codes in bits 1:0 of the texture env word
    localparam int texEnvFuncWidth = 2;
    localparam logic [texEnvFuncWidth-1:0] texEnvReplace = 2'd0;
    localparam logic [texEnvFuncWidth-1:0] texEnvModulate = 2'd1;
    localparam logic [texEnvFuncWidth-1:0] texEnvAdd = 2'd2;

    // Texture size fields, log2 of width and height, at most 8 each
    localparam int texWidthLog2Pos = 0;
    localparam int texHeightLog2Pos = 4;
    localparam int texSizeLog2Bits = 4;

endpackage

// ==== source/pixelPipelineTop.sv ====
// Pixel pipeline top level
// Nearest texel fetch, texture env combine and fog in four stages

`timescale 1ns/1ps

module pixelPipelineTop #(
    parameter int indexWidth = 14,
    parameter int screenPosWidth = 11,
    parameter int texAddrWidth = 17
) (
    input  logic aclk,
    input  logic rstN,

    // Fog table stream
    input  logic fogLutValid,
    output logic fogLutReady,
    input  logic fogLutLast,
    input  logic [31:0] fogLutData,

    // Configuration
    input  logic [31:0] confFeatureEnable,
    input  logic [31:0] confTexEnvConfig,
    input  logic [31:0] confTextureConfig,
    input  logic [pixelPipelinePkg::pixelWidth-1:0] confFogColor,

    // Fragment input
    input  logic attrbValid,
    output logic attrbReady,
    input  logic attrbLast,
    input  logic attrbKeep,
    input  logic [screenPosWidth-1:0] attrbScreenX,
    input  logic [screenPosWidth-1:0] attrbScreenY,
    input  logic [indexWidth-1:0] attrbIndex,
    input  logic [31:0] attrbDepthZ,
    input  logic [31:0] attrbDepthW,
    input  logic [pixelPipelinePkg::pixelWidth-1:0] attrbColor,
    input  logic [31:0] attrbTexS,
    input  logic [31:0] attrbTexT,

    // Texture memory
    output logic [texAddrWidth-1:0] texelAddr,
    input  logic [pixelPipelinePkg::pixelWidth-1:0] texelData,

    // Fragment output
    input  logic fragReady,
    output logic fragValid,
    output logic fragLast,
    output logic fragKeep,
    output logic [pixelPipelinePkg::pixelWidth-1:0] fragColor,
    output logic [indexWidth-1:0] fragIndex,
    output logic [screenPosWidth-1:0] fragScreenX,
    output logic [screenPosWidth-1:0] fragScreenY,
    output logic [31:0] fragDepth
);
    logic fogLutWrEn;
    logic [pixelPipelinePkg::fogLutIndexWidth-1:0] fogLutWrAddr;
    logic [pixelPipelinePkg::pixelWidth-1:0] texColor;

    pipelineCtrlIf ctrlBus ();

    pipelineControl control (
        .aclk(aclk), .rstN(rstN),
        .fragReady(fragReady), .attrbValid(attrbValid), .attrbLast(attrbLast),
        .attrbReady(attrbReady), .fragValid(fragValid), .fragLast(fragLast),
        .confFeatureEnable(confFeatureEnable), .confTexEnvConfig(confTexEnvConfig),
        .fogLutValid(fogLutValid), .fogLutLast(fogLutLast), .fogLutReady(fogLutReady),
        .fogLutWrEn(fogLutWrEn), .fogLutWrAddr(fogLutWrAddr),
        .ctrl(ctrlBus.ctrl)
    );

    sidebandDelay #(.indexWidth(indexWidth), .screenPosWidth(screenPosWidth)) sideband (
        .aclk(aclk), .rstN(rstN),
        .attrbKeep(attrbKeep), .attrbIndex(attrbIndex),
        .attrbScreenX(attrbScreenX), .attrbScreenY(attrbScreenY),
        .attrbDepthZ(attrbDepthZ),
        .fragKeep(fragKeep), .fragIndex(fragIndex),
        .fragScreenX(fragScreenX), .fragScreenY(fragScreenY), .fragDepth(fragDepth),
        .ctrl(ctrlBus.stage)
    );

    texelAddressGen #(.texAddrWidth(texAddrWidth)) addrGen (
        .aclk(aclk),
        .attrbTexS(attrbTexS), .attrbTexT(attrbTexT),
        .confTextureConfig(confTextureConfig),
        .texelAddr(texelAddr),
        .ctrl(ctrlBus.stage)
    );

    texEnvCombiner texEnv (
        .aclk(aclk),
        .attrbColor(attrbColor), .texelData(texelData),
        .texColor(texColor),
        .ctrl(ctrlBus.stage)
    );

    fogUnit fog (
        .aclk(aclk),
        .attrbDepthW(attrbDepthW), .texColor(texColor), .confFogColor(confFogColor),
        .fogLutWrEn(fogLutWrEn), .fogLutWrAddr(fogLutWrAddr), .fogLutData(fogLutData),
        .fragColor(fragColor),
        .ctrl(ctrlBus.stage)
    );

endmodule

// ==== source/sidebandDelay.sv ====
// Sideband delay line
// Carries index, screen position, Z depth and keep alongside the color

`timescale 1ns/1ps

module sidebandDelay #(
    parameter int indexWidth = 14,
    parameter int screenPosWidth = 11
) (
    input  logic aclk,
    input  logic rstN,

    input  logic attrbKeep,
    input  logic [indexWidth-1:0] attrbIndex,
    input  logic [screenPosWidth-1:0] attrbScreenX,
    input  logic [screenPosWidth-1:0] attrbScreenY,
    input  logic [31:0] attrbDepthZ,

    output logic fragKeep,
    output logic [indexWidth-1:0] fragIndex,
    output logic [screenPosWidth-1:0] fragScreenX,
    output logic [screenPosWidth-1:0] fragScreenY,
    output logic [31:0] fragDepth,

    pipelineCtrlIf.stage ctrl
);
    localparam int depth = pixelPipelinePkg::pipeDepth;
    localparam int payloadWidth = indexWidth + 2 * screenPosWidth + 32;

    logic [payloadWidth-1:0] payloadPipe [depth];
    logic [depth-1:0] keepPipe;

    // Payload fields travel as one packed word
    always_ff @(posedge aclk)
    begin
        if (ctrl.stageEnable)
        begin
            payloadPipe[0] <= {attrbIndex, attrbScreenX, attrbScreenY, attrbDepthZ};
            for (int i = 1; i < depth; i++)
                payloadPipe[i] <= payloadPipe[i-1];
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!rstN)
            keepPipe <= '0;
        else if (ctrl.stageEnable)
            keepPipe <= {keepPipe[depth-2:0], attrbKeep};
    end

    assign {fragIndex, fragScreenX, fragScreenY, fragDepth} = payloadPipe[depth-1];
    assign fragKeep = keepPipe[depth-1];

endmodule

// ==== source/texEnvCombiner.sv ====
// Texture environment combiner
// Lines the primary color up with the fetched texel and applies replace,
// modulate or add per channel

`timescale 1ns/1ps

module texEnvCombiner (
    input  logic aclk,

    input  logic [pixelPipelinePkg::pixelWidth-1:0] attrbColor,
    input  logic [pixelPipelinePkg::pixelWidth-1:0] texelData,

    output logic [pixelPipelinePkg::pixelWidth-1:0] texColor,

    pipelineCtrlIf.stage ctrl
);
    localparam int chanWidth = pixelPipelinePkg::subPixelWidth;
    localparam int chanCount = pixelPipelinePkg::pixelWidth / chanWidth;

    logic [pixelPipelinePkg::pixelWidth-1:0] primaryPipe [2];
    logic [pixelPipelinePkg::pixelWidth-1:0] texelHold;
    logic [pixelPipelinePkg::pixelWidth-1:0] texel;
    logic [pixelPipelinePkg::pixelWidth-1:0] combined;
    logic enablePrev;

    function automatic logic [chanWidth-1:0] combineChannel(
        input logic [pixelPipelinePkg::texEnvFuncWidth-1:0] func,
        input logic [chanWidth-1:0] primary,
        input logic [chanWidth-1:0] tex
    );
        logic [2*chanWidth-1:0] product;
        logic [chanWidth:0] sum;
        product = primary * tex + 16'd255;
        sum = primary + tex;
        case (func)
            pixelPipelinePkg::texEnvModulate: return product[2*chanWidth-1:chanWidth];
            pixelPipelinePkg::texEnvAdd: return sum[chanWidth] ? '1 : sum[chanWidth-1:0];
            default: return tex;
        endcase
    endfunction

    ////////////////////////////////////////
    // Texel capture
    ////////////////////////////////////////
    // Memory output matches the held address only in the cycle after an
    // enabled edge, so it is kept here across a stall
    always_ff @(posedge aclk)
    begin
        enablePrev <= ctrl.stageEnable;
        if (enablePrev)
            texelHold <= texelData;
    end

    assign texel = enablePrev ? texelData : texelHold;

    always_comb
    begin
        for (int i = 0; i < chanCount; i++)
        begin
            combined[i*chanWidth +: chanWidth] = combineChannel(ctrl.texEnvFunc,
                primaryPipe[1][i*chanWidth +: chanWidth], texel[i*chanWidth +: chanWidth]);
        end
    end

    // Primary color waits for the fetch, result at the third stage
    always_ff @(posedge aclk)
    begin
        if (ctrl.stageEnable)
        begin
            primaryPipe[0] <= attrbColor;
            primaryPipe[1] <= primaryPipe[0];
            texColor <= ctrl.tmuEnable ? combined : primaryPipe[1];
        end
    end

endmodule

// ==== source/texelAddressGen.sv ====
// Texel address generator
// Wraps S and T to the texture size and registers the nearest texel address

`timescale 1ns/1ps

module texelAddressGen #(
    parameter int texAddrWidth = 17
) (
    input  logic aclk,

    input  logic [31:0] attrbTexS,
    input  logic [31:0] attrbTexT,
    input  logic [31:0] confTextureConfig,

    output logic [texAddrWidth-1:0] texelAddr,

    pipelineCtrlIf.stage ctrl
);
    localparam int sizeBits = pixelPipelinePkg::texSizeLog2Bits;

    logic [sizeBits-1:0] widthLog2;
    logic [sizeBits-1:0] heightLog2;
    logic [15:0] intS;
    logic [15:0] intT;
    logic [15:0] wrappedS;
    logic [15:0] wrappedT;
    logic [31:0] fullAddr;

    assign widthLog2 = confTextureConfig[pixelPipelinePkg::texWidthLog2Pos +: sizeBits];
    assign heightLog2 = confTextureConfig[pixelPipelinePkg::texHeightLog2Pos +: sizeBits];

    // Integer part of S16.15
    assign intS = attrbTexS[30:15];
    assign intT = attrbTexT[30:15];

    // Masking wraps the coordinate into a repeating texture
    assign wrappedS = intS & ((16'd1 << widthLog2) - 16'd1);
    assign wrappedT = intT & ((16'd1 << heightLog2) - 16'd1);

    // Row major, one row is 2^widthLog2 texels
    assign fullAddr = ({16'd0, wrappedT} << widthLog2) | {16'd0, wrappedS};

    always_ff @(posedge aclk)
    begin
        if (ctrl.stageEnable)
            texelAddr <= fullAddr[texAddrWidth-1:0];
    end

    assert property (@(posedge aclk) ctrl.stageEnable && ctrl.tmuEnable
        |-> ({1'b0, widthLog2} + {1'b0, heightLog2} <= texAddrWidth));

endmodule

// ==== tests/pixelPipelineTb.sv ====
// Pixel pipeline testbench
// Fog table load, latency and address checks, then fragments under random back-pressure

`timescale 1ns/1ps

module pixelPipelineTb;
    localparam logic [31:0] texConfigValue = 32'h0000_0045;
    localparam logic [31:0] fogColorValue = 32'h2060_e000;

    logic aclk;
    logic rstN;
    logic fogLutValid;
    logic fogLutReady;
    logic fogLutLast;
    logic [31:0] fogLutData;
    logic [31:0] confFeatureEnable;
    logic [31:0] confTexEnvConfig;
    logic [31:0] confTextureConfig;
    logic [31:0] confFogColor;
    logic attrbValid;
    logic attrbReady;
    logic attrbLast;
    logic attrbKeep;
    logic [10:0] attrbScreenX;
    logic [10:0] attrbScreenY;
    logic [13:0] attrbIndex;
    logic [31:0] attrbDepthZ;
    logic [31:0] attrbDepthW;
    logic [31:0] attrbColor;
    logic [31:0] attrbTexS;
    logic [31:0] attrbTexT;
    logic [16:0] texelAddr;
    logic [31:0] texelData;
    logic fragReady;
    logic fragValid;
    logic fragLast;
    logic fragKeep;
    logic [31:0] fragColor;
    logic [13:0] fragIndex;
    logic [10:0] fragScreenX;
    logic [10:0] fragScreenY;
    logic [31:0] fragDepth;

    // Fragment table, one entry per row in every queue
    string rowName[$];
    logic [31:0] rowS[$];
    logic [31:0] rowT[$];
    logic [31:0] rowColor[$];
    logic [31:0] rowW[$];
    logic [31:0] rowZ[$];
    logic [31:0] rowExp[$];
    logic [16:0] rowAddr[$];
    logic [13:0] rowIndex[$];
    logic [10:0] rowX[$];
    logic [10:0] rowY[$];
    logic [1:0] rowFeat[$];
    logic [1:0] rowFunc[$];
    logic rowKeep[$];
    logic rowLast[$];

    // Rows accepted by the DUT and not yet seen at the output
    int expQueue[$];
    int rowCount;
    int rowIdx;
    int cycleCount = 0;
    int cycleLimit = 1000;
    int unsigned seedValue;
    logic ready;

    pixelPipelineTop #(.indexWidth(14), .screenPosWidth(11), .texAddrWidth(17)) dut0 (.*);

    texelMemModel #(.addrWidth(17)) texMem (
        .aclk(aclk),
        .addr(texelAddr),
        .data(texelData)
    );

    initial
    begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    always @(posedge aclk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            $display("tests failed");
            $fatal(1, "Run did not finish within %0d cycles", cycleLimit);
        end
    end

    ////////////////////////////////////////
    // Reference rules
    ////////////////////////////////////////
    function automatic logic [31:0] coord(input int intPart, input int frac);
        return (32'(intPart) << 15) | 32'(frac);
    endfunction

    function automatic logic [7:0] fogFactorAt(input int i);
        return 8'(255 - 8 * i);
    endfunction

    function automatic logic [16:0] texelAddrFor(input logic [31:0] s, input logic [31:0] t);
        int widthLog2;
        int heightLog2;
        int wrappedS;
        int wrappedT;
        widthLog2 = int'(texConfigValue[3:0]);
        heightLog2 = int'(texConfigValue[7:4]);
        // Repeating texture, integer part modulo the size
        wrappedS = int'(s[30:15]) % (1 << widthLog2);
        wrappedT = int'(t[30:15]) % (1 << heightLog2);
        return 17'(wrappedT * (1 << widthLog2) + wrappedS);
    endfunction

    function automatic logic [31:0] texelAt(input logic [16:0] a);
        return {a[7:0], ~a[7:0], a[15:8] ^ {7'd0, a[16]}, 8'hff};
    endfunction

    function automatic logic [7:0] texEnvChannel(input logic [1:0] func,
            input logic [7:0] p, input logic [7:0] t);
        int sum;
        sum = int'(p) + int'(t);
        case (func)
            2'd1: return 8'((int'(p) * int'(t) + 255) / 256);
            2'd2: return (sum > 255) ? 8'd255 : 8'(sum);
            default: return t;
        endcase
    endfunction

    function automatic logic [7:0] fogChannel(input logic [7:0] c, input logic [7:0] fog,
            input int f);
        return 8'((int'(c) * f + int'(fog) * (255 - f) + 255) / 256);
    endfunction

    function automatic logic [31:0] expectedColor(input logic [31:0] color,
            input logic [16:0] addr, input logic [31:0] w, input logic [1:0] feat,
            input logic [1:0] func);
        logic [31:0] texel;
        logic [31:0] tex;
        logic [31:0] result;
        int wIndex;
        int f;
        texel = texelAt(addr);
        for (int ch = 0; ch < 4; ch++)
        begin
            tex[8*ch +: 8] = feat[0] ? texEnvChannel(func, color[8*ch +: 8], texel[8*ch +: 8])
                                     : color[8*ch +: 8];
        end
        wIndex = (int'(w[31:16]) > 31) ? 31 : int'(w[31:16]);
        f = int'(fogFactorAt(wIndex));
        result = tex;
        // Alpha is never fogged
        if (feat[1])
        begin
            for (int ch = 1; ch < 4; ch++)
                result[8*ch +: 8] = fogChannel(tex[8*ch +: 8], fogColorValue[8*ch +: 8], f);
        end
        return result;
    endfunction

    ////////////////////////////////////////
    // Table and driving
    ////////////////////////////////////////
    task automatic addRow(input string name, input logic [31:0] s, input logic [31:0] t,
            input logic [31:0] color, input logic [31:0] w, input logic [1:0] feat,
            input logic [1:0] func);
        int n;
        logic [16:0] addr;
        n = rowName.size();
        addr = texelAddrFor(s, t);
        rowName.push_back(name);
        rowS.push_back(s);
        rowT.push_back(t);
        rowColor.push_back(color);
        rowW.push_back(w);
        rowFeat.push_back(feat);
        rowFunc.push_back(func);
        rowAddr.push_back(addr);
        rowIndex.push_back(14'(n * 37 + 5));
        rowX.push_back(11'(n * 13));
        rowY.push_back(11'(2047 - n * 9));
        rowZ.push_back(32'h1000_0000 + 32'(n) * 32'h0101_0101);
        rowKeep.push_back(n[0]);
        rowLast.push_back(n % 4 == 3);
        rowExp.push_back(expectedColor(color, addr, w, feat, func));
    endtask

    function automatic logic randomReady();
        return ($urandom % 4) != 0;
    endfunction

    task automatic checkValue(input string name, input logic [63:0] expected,
            input logic [63:0] actual);
        if (expected !== actual)
        begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
            $display("tests failed");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic checkOutput();
        int r;
        if (expQueue.size() == 0)
        begin
            $display("A fragment came out while none was in flight");
            $display("tests failed");
            $fatal(1, "Unexpected output fragment");
        end
        r = expQueue.pop_front();
        checkValue({rowName[r], " color"}, rowExp[r], fragColor);
        checkValue({rowName[r], " index"}, rowIndex[r], fragIndex);
        checkValue({rowName[r], " screen x"}, rowX[r], fragScreenX);
        checkValue({rowName[r], " screen y"}, rowY[r], fragScreenY);
        checkValue({rowName[r], " depth"}, rowZ[r], fragDepth);
        checkValue({rowName[r], " keep"}, rowKeep[r], fragKeep);
        checkValue({rowName[r], " last"}, rowLast[r], fragLast);
    endtask

    // An output shown now with ready set is taken at the next rising edge
    task automatic advanceCycle(input logic readyValue);
        @(negedge aclk);
        checkValue("attrbReady follows fragReady", fragReady, attrbReady);
        if (fragValid && readyValue)
            checkOutput();
        fragReady = readyValue;
    endtask

    task automatic driveRow(input int r);
        confFeatureEnable = {30'd0, rowFeat[r]};
        confTexEnvConfig = {30'd0, rowFunc[r]};
        attrbTexS = rowS[r];
        attrbTexT = rowT[r];
        attrbColor = rowColor[r];
        attrbDepthW = rowW[r];
        attrbDepthZ = rowZ[r];
        attrbIndex = rowIndex[r];
        attrbScreenX = rowX[r];
        attrbScreenY = rowY[r];
        attrbKeep = rowKeep[r];
        attrbLast = rowLast[r];
        attrbValid = 1'b1;
    endtask

    task automatic loadFogTable();
        for (int i = 0; i < 32; i++)
        begin
            @(negedge aclk);
            checkValue("fog table ready", 1'b1, fogLutReady);
            fogLutValid = 1'b1;
            fogLutLast = (i == 31);
            // Upper bits carry junk that must be ignored
            fogLutData = {8'(i * 7), 16'ha55a, fogFactorAt(i)};
        end
        @(negedge aclk);
        fogLutValid = 1'b0;
        fogLutLast = 1'b0;
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial
    begin
        seedValue = $urandom(32'h0b47_65f5);
        rstN = 1'b0;
        fogLutValid = 1'b0;
        fogLutLast = 1'b0;
        fogLutData = '0;
        confFeatureEnable = '0;
        confTexEnvConfig = '0;
        confTextureConfig = texConfigValue;
        confFogColor = fogColorValue;
        attrbValid = 1'b0;
        attrbLast = 1'b0;
        attrbKeep = 1'b0;
        attrbScreenX = '0;
        attrbScreenY = '0;
        attrbIndex = '0;
        attrbDepthZ = '0;
        attrbDepthW = '0;
        attrbColor = '0;
        attrbTexS = '0;
        attrbTexT = '0;
        fragReady = 1'b0;

        addRow("replace wrap", coord(70, 'h1234), coord(21, 0), 32'h1122_3344,
            32'h0005_0000, 2'b01, 2'd0);
        addRow("replace fraction", coord(3, 'h7fff), coord(2, 'h4000), 32'h5566_7788,
            32'h0001_0000, 2'b01, 2'd0);
        addRow("code 3 as replace", coord(31, 0), coord(15, 'h10), 32'h99aa_bbcc,
            32'h0000_0000, 2'b01, 2'd3);
        addRow("modulate", coord(9, 0), coord(5, 0), 32'h80ff_40c0, 32'h0, 2'b01, 2'd1);
        addRow("modulate white", coord(100, 'h100), coord(40, 0), 32'hffff_ffff,
            32'h0, 2'b01, 2'd1);
        addRow("add saturate", coord(17, 0), coord(9, 0), 32'hc0c0_c0c0, 32'h0, 2'b01, 2'd2);
        addRow("add small", coord(0, 0), coord(0, 0), 32'h0102_0304, 32'h0, 2'b01, 2'd2);
        addRow("texture off", coord(12, 0), coord(6, 0), 32'h3c5a_7896, 32'h0, 2'b00, 2'd1);
        addRow("fog near", coord(4, 0), coord(3, 0), 32'hf0e0_d0c0, 32'h0, 2'b11, 2'd0);
        addRow("fog mid modulate", coord(25, 'h2000), coord(11, 0), 32'h8080_8080,
            32'h000c_8000, 2'b11, 2'd1);
        addRow("fog far", coord(1, 0), coord(1, 0), 32'h40c0_ff10, 32'h00c8_0000, 2'b10, 2'd0);
        addRow("fog above table", coord(63, 0), coord(31, 0), 32'h2040_6080,
            32'h0100_0000, 2'b11, 2'd2);
        addRow("fog off", coord(7, 0), coord(8, 0), 32'h0f1e_2d3c, 32'h0007_0000, 2'b01, 2'd2);
        addRow("negative wrap", coord(-1, 0), coord(-3, 'h1), 32'h7766_5544,
            32'h001f_ffff, 2'b11, 2'd1);
        rowCount = rowName.size();
        cycleLimit = (rowCount + 32) * 8 + 100;

        repeat (2) @(posedge aclk);
        @(negedge aclk);
        checkValue("reset fragValid", 1'b0, fragValid);
        checkValue("reset fragLast", 1'b0, fragLast);
        checkValue("reset fragKeep", 1'b0, fragKeep);
        checkValue("reset fogLutReady", 1'b1, fogLutReady);
        rstN = 1'b1;

        loadFogTable();

        // One fragment at a time with ready held high
        for (int r = 0; r < rowCount; r++)
        begin
            advanceCycle(1'b1);
            driveRow(r);
            expQueue.push_back(r);
            for (int k = 1; k <= 4; k++)
            begin
                advanceCycle(1'b1);
                attrbValid = 1'b0;
                if (k == 1)
                    checkValue({rowName[r], " texel address"}, rowAddr[r], texelAddr);
                checkValue({rowName[r], " latency"}, (k == 4), fragValid);
            end
        end

        // Streamed with random back-pressure, drained before a config change
        rowIdx = 0;
        while (rowIdx < rowCount)
        begin
            ready = randomReady();
            advanceCycle(ready);
            if (expQueue.size() != 0 && (rowFeat[rowIdx] != confFeatureEnable[1:0]
                    || rowFunc[rowIdx] != confTexEnvConfig[1:0]))
            begin
                attrbValid = 1'b0;
            end
            else
            begin
                driveRow(rowIdx);
                if (ready)
                begin
                    expQueue.push_back(rowIdx);
                    rowIdx++;
                end
            end
        end

        while (expQueue.size() != 0)
        begin
            advanceCycle(randomReady());
            attrbValid = 1'b0;
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== tests/texelMemModel.sv ====
// Texture memory model
// Synchronous read with one cycle of latency, texel is a fixed function of its address

`timescale 1ns/1ps

module texelMemModel #(
    parameter int addrWidth = 17
) (
    input  logic aclk,
    input  logic [addrWidth-1:0] addr,
    output logic [31:0] data
);
    logic [31:0] wideAddr;

    assign wideAddr = 32'(addr);

    // Red is the low byte, green its inverse, blue the next byte
    // Bits above 15 fold into blue so every address bit shows
    always_ff @(posedge aclk)
    begin
        data <= {
            wideAddr[7:0],
            ~wideAddr[7:0],
            wideAddr[15:8] ^ wideAddr[23:16],
            8'hff
        };
    end

endmodule

// ==== vlog.f ====
source/pixelPipelinePkg.sv
source/pipelineCtrlIf.sv
source/pipelineControl.sv
source/sidebandDelay.sv
source/texelAddressGen.sv
source/texEnvCombiner.sv
source/fogUnit.sv
source/pixelPipelineTop.sv
tests/texelMemModel.sv
tests/pixelPipelineTb.sv
